// File: rtl/rp_pkg.sv
// shared definitions for the instrument fabric
// widths, region map, register offsets, bus address view and code helpers
`default_nettype none

package rp_pkg;

  // ------------------------------
  // widths
  localparam int ADC_W    = 14;                          // sample width
  localparam int SUM_W    = 15;                          // sums before saturation
  localparam int SYS_W    = 32;                          // bus data and address
  localparam int REGION_W = 10;                          // region index field
  localparam int OFFSET_W = 20;                          // in-region offset field

  localparam int ADC_MAX  = 2 ** (ADC_W - 1) - 1;        // +8191
  localparam int ADC_MIN  = -(2 ** (ADC_W - 1));         // -8192

  // ------------------------------
  // region map
  localparam int SYS_REGIONS = 8;                        // decoded regions
  localparam int REGION_HK   = 0;
  localparam int REGION_MIX  = 1;
  localparam int REGION_PID  = 2;                        // last used one, rest free
  localparam logic [REGION_W-1:0] SYSCONF_REGION = '1;   // config region, all ones

  localparam logic [SYS_W-1:0]    SYSCONF_ID          = 32'hfff00001;
  localparam logic [OFFSET_W-1:0] SYSCONF_ID_OFS      = 20'hf0000;
  localparam logic [OFFSET_W-1:0] SYSCONF_REGIONS_OFS = 20'hf0004;

  // ------------------------------
  // register offsets
  localparam logic [OFFSET_W-1:0] HK_EXP_OFS = 20'h00;   // expansion inputs, ro
  localparam logic [OFFSET_W-1:0] HK_LED_OFS = 20'h30;   // leds, rw
  localparam logic [OFFSET_W-1:0] MIX_OFS_A  = 20'h00;
  localparam logic [OFFSET_W-1:0] MIX_OFS_B  = 20'h04;
  localparam logic [OFFSET_W-1:0] PID_SP_A   = 20'h00;
  localparam logic [OFFSET_W-1:0] PID_KP_A   = 20'h04;
  localparam logic [OFFSET_W-1:0] PID_SP_B   = 20'h08;
  localparam logic [OFFSET_W-1:0] PID_KP_B   = 20'h0c;

  localparam int PID_SHIFT = 12;                         // product scaling

  // bus address, raw or split into region and offset
  typedef struct packed {
    logic [1:0]          unused;
    logic [REGION_W-1:0] region;
    logic [OFFSET_W-1:0] offset;
  } sys_addr_fields_t;

  typedef union packed {
    logic [SYS_W-1:0] raw;
    sys_addr_fields_t f;
  } sys_addr_t;

  // offset binary, negative slope <-> two's complement, same rule both ways
  function automatic logic [ADC_W-1:0] flip_code(input logic [ADC_W-1:0] d);
    return {d[ADC_W-1], ~d[ADC_W-2:0]};
  endfunction

  // clamp a wide signed value to the sample range
  function automatic logic signed [ADC_W-1:0] sat_adc(input logic signed [SYS_W-1:0] v);
    if (v > ADC_MAX) return ADC_W'(ADC_MAX);             // 1fff
    if (v < ADC_MIN) return ADC_W'(ADC_MIN);             // 2000
    return v[ADC_W-1:0];
  endfunction

endpackage

`default_nettype wire

// File: rtl/sys_bus_decoder.sv
// system bus decoder, splits the address into regions and muxes the returns
// also answers the config region, the free regions and stray addresses itself
`default_nettype none

module sys_bus_decoder (
  input  logic                                          adc_clk,
  input  logic                                          rst_n_i,
  input  rp_pkg::sys_addr_t                             sys_addr_i,
  input  logic                                          sys_wen_i,
  input  logic                                          sys_ren_i,
  output logic [rp_pkg::SYS_REGIONS-1:0]                region_wen_o,
  output logic [rp_pkg::SYS_REGIONS-1:0]                region_ren_o,
  input  logic [rp_pkg::SYS_REGIONS-1:0][rp_pkg::SYS_W-1:0] region_rdata_i,
  input  logic [rp_pkg::SYS_REGIONS-1:0]                region_ack_i,
  output logic [rp_pkg::SYS_W-1:0]                      sys_rdata_o,
  output logic                                          sys_ack_o,
  output logic                                          sys_err_o
);
  import rp_pkg::*;

  logic [REGION_W-1:0]              region;
  logic [$clog2(SYS_REGIONS)-1:0]   region_idx;
  logic                             in_range;
  logic                             conf_hit;
  logic                             free_hit;
  logic                             live_hit;
  logic [SYS_REGIONS-1:0]           region_sel;
  logic                             loc_ack_q;
  logic                             loc_err_q;
  logic [SYS_W-1:0]                 loc_rdata_q;

  // ------------------------------
  // region decode
  assign region     = sys_addr_i.f.region;
  assign region_idx = region[$clog2(SYS_REGIONS)-1:0];
  assign in_range   = region < SYS_REGIONS;
  assign conf_hit   = region == SYSCONF_REGION;
  assign free_hit   = in_range && (region > REGION_PID);  // no block behind it
  assign live_hit   = in_range && !free_hit;              // a region block answers

  assign region_sel   = in_range ? (SYS_REGIONS'(1) << region_idx) : '0;
  assign region_wen_o = region_sel & {SYS_REGIONS{sys_wen_i}};
  assign region_ren_o = region_sel & {SYS_REGIONS{sys_ren_i}};

  // ------------------------------
  // local answers, one cycle after the strobe
  always_ff @(posedge adc_clk) begin
    if (!rst_n_i) begin
      loc_ack_q <= 1'b0;
      loc_err_q <= 1'b0;
    end else begin
      loc_ack_q <= (sys_wen_i | sys_ren_i) & !live_hit;
      loc_err_q <= (sys_wen_i | sys_ren_i) & !in_range & !conf_hit;  // stray address
    end
  end

  always_ff @(posedge adc_clk) begin
    if (sys_ren_i) begin
      if (conf_hit) begin
        case (sys_addr_i.f.offset)
          SYSCONF_ID_OFS:      loc_rdata_q <= SYSCONF_ID;
          SYSCONF_REGIONS_OFS: loc_rdata_q <= SYS_W'(SYS_REGIONS);
          default:             loc_rdata_q <= '0;
        endcase
      end else begin
        loc_rdata_q <= '0;                                 // free or stray reads zero
      end
    end
  end

  // ------------------------------
  // return path, address is held until ack
  always_comb begin
    if (live_hit) begin
      sys_rdata_o = region_rdata_i[region_idx];
      sys_ack_o   = region_ack_i[region_idx];
    end else begin
      sys_rdata_o = loc_rdata_q;
      sys_ack_o   = loc_ack_q;
    end
  end

  assign sys_err_o = loc_err_q;                            // region blocks never fail

endmodule

`default_nettype wire

// File: rtl/hk_regs.sv
// housekeeping region, LED register and expansion input readback
`default_nettype none

module hk_regs (
  input  logic                     adc_clk,
  input  logic                     rst_n_i,
  input  rp_pkg::sys_addr_t        sys_addr_i,
  input  logic [rp_pkg::SYS_W-1:0] sys_wdata_i,
  input  logic                     sys_wen_i,
  input  logic                     sys_ren_i,
  output logic [rp_pkg::SYS_W-1:0] sys_rdata_o,
  output logic                     sys_ack_o,
  input  logic [7:0]               exp_i,
  output logic [7:0]               led_o
);
  import rp_pkg::*;

  always_ff @(posedge adc_clk) begin
    if (!rst_n_i) begin
      led_o     <= '0;
      sys_ack_o <= 1'b0;
    end else begin
      sys_ack_o <= sys_wen_i | sys_ren_i;                  // ack next cycle, always
      if (sys_wen_i && (sys_addr_i.f.offset == HK_LED_OFS))
        led_o <= sys_wdata_i[7:0];                         // whole word write, low byte kept
    end
  end

  // readback, sampled on the read strobe
  always_ff @(posedge adc_clk) begin
    if (sys_ren_i) begin
      case (sys_addr_i.f.offset)
        HK_EXP_OFS: sys_rdata_o <= SYS_W'(exp_i);
        HK_LED_OFS: sys_rdata_o <= SYS_W'(led_o);
        default:    sys_rdata_o <= '0;
      endcase
    end
  end

endmodule

`default_nettype wire

// File: rtl/adc_frontend.sv
// ADC front end, offset binary negative slope to two's complement
`default_nettype none

module adc_frontend (
  input  logic                            adc_clk,
  input  logic                            rst_n_i,
  input  logic [rp_pkg::ADC_W-1:0]        adc_dat_a_i,
  input  logic [rp_pkg::ADC_W-1:0]        adc_dat_b_i,
  output logic signed [rp_pkg::ADC_W-1:0] adc_a_o,
  output logic signed [rp_pkg::ADC_W-1:0] adc_b_o
);
  import rp_pkg::*;

  // one register stage, msb kept, rest inverted
  always_ff @(posedge adc_clk) begin
    if (!rst_n_i) begin
      adc_a_o <= '0;
      adc_b_o <= '0;
    end else begin
      adc_a_o <= flip_code(adc_dat_a_i);                   // ch a
      adc_b_o <= flip_code(adc_dat_b_i);                   // ch b
    end
  end

endmodule

`default_nettype wire

// File: rtl/pid_p.sv
// proportional controller region, kp * (setpoint - sample) per channel
// product registered, then shifted, saturated and registered again
`default_nettype none

module pid_p (
  input  logic                            adc_clk,
  input  logic                            rst_n_i,
  input  rp_pkg::sys_addr_t               sys_addr_i,
  input  logic [rp_pkg::SYS_W-1:0]        sys_wdata_i,
  input  logic                            sys_wen_i,
  input  logic                            sys_ren_i,
  output logic [rp_pkg::SYS_W-1:0]        sys_rdata_o,
  output logic                            sys_ack_o,
  input  logic signed [rp_pkg::ADC_W-1:0] dat_a_i,
  input  logic signed [rp_pkg::ADC_W-1:0] dat_b_i,
  output logic signed [rp_pkg::ADC_W-1:0] dat_a_o,
  output logic signed [rp_pkg::ADC_W-1:0] dat_b_o
);
  import rp_pkg::*;

  logic signed [ADC_W-1:0]       sp_q   [2];               // setpoints
  logic signed [ADC_W-1:0]       kp_q   [2];               // gains
  logic signed [ADC_W-1:0]       dat_in [2];
  logic signed [SUM_W-1:0]       err    [2];               // sp - sample
  logic signed [SUM_W+ADC_W-1:0] prod_q [2];               // stage 1
  logic signed [ADC_W-1:0]       out_q  [2];               // stage 2

  assign dat_in[0] = dat_a_i;
  assign dat_in[1] = dat_b_i;

  // ------------------------------
  // bus registers
  always_ff @(posedge adc_clk) begin
    if (!rst_n_i) begin
      sys_ack_o <= 1'b0;
      for (int i = 0; i < 2; i++) begin
        sp_q[i] <= '0;
        kp_q[i] <= '0;
      end
    end else begin
      sys_ack_o <= sys_wen_i | sys_ren_i;
      if (sys_wen_i) begin
        case (sys_addr_i.f.offset)
          PID_SP_A: sp_q[0] <= sys_wdata_i[ADC_W-1:0];
          PID_KP_A: kp_q[0] <= sys_wdata_i[ADC_W-1:0];
          PID_SP_B: sp_q[1] <= sys_wdata_i[ADC_W-1:0];
          PID_KP_B: kp_q[1] <= sys_wdata_i[ADC_W-1:0];
          default: ;                                       // unmapped, ignored
        endcase
      end
    end
  end

  always_ff @(posedge adc_clk) begin
    if (sys_ren_i) begin
      case (sys_addr_i.f.offset)
        PID_SP_A: sys_rdata_o <= SYS_W'(sp_q[0]);          // sign extended
        PID_KP_A: sys_rdata_o <= SYS_W'(kp_q[0]);
        PID_SP_B: sys_rdata_o <= SYS_W'(sp_q[1]);
        PID_KP_B: sys_rdata_o <= SYS_W'(kp_q[1]);
        default:  sys_rdata_o <= '0;
      endcase
    end
  end

  // ------------------------------
  // datapath, two stages
  always_comb begin
    for (int i = 0; i < 2; i++)
      err[i] = sp_q[i] - dat_in[i];                        // 15 bit, no wrap
  end

  always_ff @(posedge adc_clk) begin
    if (!rst_n_i) begin
      for (int i = 0; i < 2; i++) begin
        prod_q[i] <= '0;
        out_q[i]  <= '0;
      end
    end else begin
      for (int i = 0; i < 2; i++) begin
        prod_q[i] <= err[i] * kp_q[i];
        out_q[i]  <= sat_adc(prod_q[i] >>> PID_SHIFT);     // arith shift, then clamp
      end
    end
  end

  assign dat_a_o = out_q[0];
  assign dat_b_o = out_q[1];

endmodule

`default_nettype wire

// File: rtl/dac_mixer.sv
// DAC mixer region, bus offset plus controller output, saturated
// result converted back to the DAC coding and registered
`default_nettype none

module dac_mixer (
  input  logic                            adc_clk,
  input  logic                            rst_n_i,
  input  rp_pkg::sys_addr_t               sys_addr_i,
  input  logic [rp_pkg::SYS_W-1:0]        sys_wdata_i,
  input  logic                            sys_wen_i,
  input  logic                            sys_ren_i,
  output logic [rp_pkg::SYS_W-1:0]        sys_rdata_o,
  output logic                            sys_ack_o,
  input  logic signed [rp_pkg::ADC_W-1:0] pid_a_i,
  input  logic signed [rp_pkg::ADC_W-1:0] pid_b_i,
  output logic [rp_pkg::ADC_W-1:0]        dac_dat_a_o,
  output logic [rp_pkg::ADC_W-1:0]        dac_dat_b_o
);
  import rp_pkg::*;

  logic signed [ADC_W-1:0] ofs_q  [2];                     // per channel offset
  logic signed [ADC_W-1:0] pid_in [2];
  logic signed [SUM_W-1:0] sum    [2];
  logic [ADC_W-1:0]        dac_q  [2];                     // dac coded

  assign pid_in[0] = pid_a_i;
  assign pid_in[1] = pid_b_i;

  // ------------------------------
  // offset registers
  always_ff @(posedge adc_clk) begin
    if (!rst_n_i) begin
      sys_ack_o <= 1'b0;
      ofs_q[0]  <= '0;
      ofs_q[1]  <= '0;
    end else begin
      sys_ack_o <= sys_wen_i | sys_ren_i;
      if (sys_wen_i && (sys_addr_i.f.offset == MIX_OFS_A))
        ofs_q[0] <= sys_wdata_i[ADC_W-1:0];
      if (sys_wen_i && (sys_addr_i.f.offset == MIX_OFS_B))
        ofs_q[1] <= sys_wdata_i[ADC_W-1:0];
    end
  end

  always_ff @(posedge adc_clk) begin
    if (sys_ren_i) begin
      case (sys_addr_i.f.offset)
        MIX_OFS_A: sys_rdata_o <= SYS_W'(ofs_q[0]);
        MIX_OFS_B: sys_rdata_o <= SYS_W'(ofs_q[1]);
        default:   sys_rdata_o <= '0;
      endcase
    end
  end

  // ------------------------------
  // sum, clamp to 1fff / 2000, code
  always_comb begin
    for (int i = 0; i < 2; i++)
      sum[i] = ofs_q[i] + pid_in[i];
  end

  always_ff @(posedge adc_clk) begin
    if (!rst_n_i) begin
      dac_q[0] <= flip_code('0);                           // code of zero, 1fff
      dac_q[1] <= flip_code('0);
    end else begin
      for (int i = 0; i < 2; i++)
        dac_q[i] <= flip_code(sat_adc(sum[i]));
    end
  end

  assign dac_dat_a_o = dac_q[0];
  assign dac_dat_b_o = dac_q[1];

endmodule

`default_nettype wire

// File: rtl/rp_top.sv
// instrument fabric top, bus decoder, housekeeping and the ADC to DAC chain
`default_nettype none

module rp_top (
  input  logic                     adc_clk,
  input  logic                     rst_n_i,
  input  logic [rp_pkg::ADC_W-1:0] adc_dat_a_i,
  input  logic [rp_pkg::ADC_W-1:0] adc_dat_b_i,
  input  logic [7:0]               exp_i,
  input  rp_pkg::sys_addr_t        sys_addr_i,
  input  logic [rp_pkg::SYS_W-1:0] sys_wdata_i,
  input  logic                     sys_wen_i,
  input  logic                     sys_ren_i,
  output logic [rp_pkg::SYS_W-1:0] sys_rdata_o,
  output logic                     sys_ack_o,
  output logic                     sys_err_o,
  output logic [7:0]               led_o,
  output logic [rp_pkg::ADC_W-1:0] dac_dat_a_o,
  output logic [rp_pkg::ADC_W-1:0] dac_dat_b_o
);
  import rp_pkg::*;

  logic [SYS_REGIONS-1:0]            region_wen;
  logic [SYS_REGIONS-1:0]            region_ren;
  logic [SYS_REGIONS-1:0][SYS_W-1:0] region_rdata;
  logic [SYS_REGIONS-1:0]            region_ack;
  logic signed [ADC_W-1:0]           adc_a, adc_b;         // two's complement samples
  logic signed [ADC_W-1:0]           pid_a, pid_b;

  // ------------------------------
  // bus
  sys_bus_decoder dec_i (
    .adc_clk(adc_clk), .rst_n_i(rst_n_i),
    .sys_addr_i(sys_addr_i), .sys_wen_i(sys_wen_i), .sys_ren_i(sys_ren_i),
    .region_wen_o(region_wen), .region_ren_o(region_ren),
    .region_rdata_i(region_rdata), .region_ack_i(region_ack),
    .sys_rdata_o(sys_rdata_o), .sys_ack_o(sys_ack_o), .sys_err_o(sys_err_o)
  );

  // free slots stay quiet, decoder answers them
  assign region_rdata[SYS_REGIONS-1:REGION_PID+1] = '0;
  assign region_ack[SYS_REGIONS-1:REGION_PID+1]   = '0;

  hk_regs hk_i (
    .adc_clk(adc_clk), .rst_n_i(rst_n_i),
    .sys_addr_i(sys_addr_i), .sys_wdata_i(sys_wdata_i),
    .sys_wen_i(region_wen[REGION_HK]), .sys_ren_i(region_ren[REGION_HK]),
    .sys_rdata_o(region_rdata[REGION_HK]), .sys_ack_o(region_ack[REGION_HK]),
    .exp_i(exp_i), .led_o(led_o)
  );

  // ------------------------------
  // adc -> pid -> mixer -> dac, 4 cycles
  adc_frontend adc_i (
    .adc_clk(adc_clk), .rst_n_i(rst_n_i),
    .adc_dat_a_i(adc_dat_a_i), .adc_dat_b_i(adc_dat_b_i),
    .adc_a_o(adc_a), .adc_b_o(adc_b)
  );

  pid_p pid_i (
    .adc_clk(adc_clk), .rst_n_i(rst_n_i),
    .sys_addr_i(sys_addr_i), .sys_wdata_i(sys_wdata_i),
    .sys_wen_i(region_wen[REGION_PID]), .sys_ren_i(region_ren[REGION_PID]),
    .sys_rdata_o(region_rdata[REGION_PID]), .sys_ack_o(region_ack[REGION_PID]),
    .dat_a_i(adc_a), .dat_b_i(adc_b), .dat_a_o(pid_a), .dat_b_o(pid_b)
  );

  dac_mixer mix_i (
    .adc_clk(adc_clk), .rst_n_i(rst_n_i),
    .sys_addr_i(sys_addr_i), .sys_wdata_i(sys_wdata_i),
    .sys_wen_i(region_wen[REGION_MIX]), .sys_ren_i(region_ren[REGION_MIX]),
    .sys_rdata_o(region_rdata[REGION_MIX]), .sys_ack_o(region_ack[REGION_MIX]),
    .pid_a_i(pid_a), .pid_b_i(pid_b),
    .dac_dat_a_o(dac_dat_a_o), .dac_dat_b_o(dac_dat_b_o)
  );

endmodule

`default_nettype wire

// File: verif/tb_rp_top.sv
// testbench for the instrument fabric top
// bus decode, housekeeping and the ADC to DAC chain against a reference model
`default_nettype none

module tb_rp_top;
  import rp_pkg::*;

  localparam int TIMEOUT = 20;                             // cycles allowed per wait

  logic        adc_clk = 1'b0;
  logic        rst_n;
  logic [13:0] adc_a, adc_b;                               // raw adc codes
  logic [7:0]  exp_val;
  logic [31:0] sys_addr, sys_wdata;
  logic        sys_wen, sys_ren;
  logic [31:0] sys_rdata;
  logic        sys_ack, sys_err;
  logic [7:0]  led;
  logic [13:0] dac_a, dac_b;

  integer      seed;
  logic [31:0] rd_data;                                    // last read result
  logic        rd_err;
  int          sp_m  [2];                                  // model of the bus registers
  int          kp_m  [2];
  int          ofs_m [2];
  logic [13:0] pipe_a [4];                                 // expected dac codes in flight
  logic [13:0] pipe_b [4];
  int          fill;
  logic        check_en;

  always #5 adc_clk = ~adc_clk;

  rp_top dut_i (
    .adc_clk(adc_clk), .rst_n_i(rst_n),
    .adc_dat_a_i(adc_a), .adc_dat_b_i(adc_b), .exp_i(exp_val),
    .sys_addr_i(sys_addr), .sys_wdata_i(sys_wdata),
    .sys_wen_i(sys_wen), .sys_ren_i(sys_ren),
    .sys_rdata_o(sys_rdata), .sys_ack_o(sys_ack), .sys_err_o(sys_err),
    .led_o(led), .dac_dat_a_o(dac_a), .dac_dat_b_o(dac_b)
  );

  // ------------------------------
  // reference model
  function automatic int adc_value(input logic [13:0] code);
    return 8191 - int'(code);                              // negative slope, offset binary
  endfunction

  function automatic logic [13:0] dac_code(input int v);
    return 14'(8191 - v);
  endfunction

  function automatic int clamp14(input int v);
    if (v > 8191)
      return 8191;
    if (v < -8192)
      return -8192;
    return v;
  endfunction

  function automatic int sext14(input logic [31:0] d);
    return int'($signed(d[13:0]));                         // registers keep the low 14 bits
  endfunction

  function automatic logic [13:0] dac_ref(input logic [13:0] code, input int sp,
                                          input int kp, input int ofs);
    longint prod;
    int     ctrl;
    prod = longint'(sp - adc_value(code)) * longint'(kp);
    ctrl = clamp14(int'(prod >>> PID_SHIFT));              // floor shift, then clamp
    return dac_code(clamp14(ofs + ctrl));
  endfunction

  function automatic logic [31:0] make_addr(input logic [9:0] region, input logic [19:0] ofs);
    return {2'b00, region, ofs};
  endfunction

  // ------------------------------
  // checks and bus access
  task automatic check_value(input string name, input logic [31:0] expected,
                             input logic [31:0] actual);
    if (actual !== expected) begin
      $display("FAIL t=%0t %s expected %h got %h", $time, name, expected, actual);
      $display("Testbench failed");
      $fatal(1, "value mismatch");
    end
  endtask

  task automatic wait_ack();
    int n;
    n = 0;
    do begin
      @(posedge adc_clk);
      #1;
      sys_wen = 1'b0;                                      // strobe lasts one cycle
      sys_ren = 1'b0;
      n++;
      if (n > TIMEOUT) begin
        $display("bus access at %h was never acknowledged", sys_addr);
        $display("Testbench failed");
        $fatal(1, "bus timeout");
      end
    end while (sys_ack !== 1'b1);
    check_value("ack latency", 1, n);
    rd_data = sys_rdata;
    rd_err  = sys_err;
    @(posedge adc_clk);
    #1;
    check_value("sys_ack_o width", 0, sys_ack);            // exactly one cycle
  endtask

  task automatic bus_write(input logic [31:0] addr, input logic [31:0] data);
    check_en  = 1'b0;                                      // model restarts after writes
    sys_addr  = addr;
    sys_wdata = data;
    sys_wen   = 1'b1;
    wait_ack();
  endtask

  task automatic bus_read(input logic [31:0] addr);
    sys_addr = addr;
    sys_ren  = 1'b1;
    wait_ack();
  endtask

  task automatic set_offsets(input int a, input int b);
    bus_write(make_addr(REGION_MIX, MIX_OFS_A), 32'(a));
    bus_write(make_addr(REGION_MIX, MIX_OFS_B), 32'(b));
    ofs_m[0] = sext14(32'(a));
    ofs_m[1] = sext14(32'(b));
    bus_read(make_addr(REGION_MIX, MIX_OFS_A));
    check_value("sys_rdata_o", 32'(ofs_m[0]), rd_data);   // signed, read back extended
    bus_read(make_addr(REGION_MIX, MIX_OFS_B));
    check_value("sys_rdata_o", 32'(ofs_m[1]), rd_data);
  endtask

  task automatic set_gains(input int ch, input int sp, input int kp);
    bus_write(make_addr(REGION_PID, ch ? PID_SP_B : PID_SP_A), 32'(sp));
    bus_write(make_addr(REGION_PID, ch ? PID_KP_B : PID_KP_A), 32'(kp));
    sp_m[ch] = sext14(32'(sp));
    kp_m[ch] = sext14(32'(kp));
    bus_read(make_addr(REGION_PID, ch ? PID_SP_B : PID_SP_A));
    check_value("sys_rdata_o", 32'(sp_m[ch]), rd_data);
    bus_read(make_addr(REGION_PID, ch ? PID_KP_B : PID_KP_A));
    check_value("sys_rdata_o", 32'(kp_m[ch]), rd_data);
  endtask

  task automatic run_random(input int n);
    repeat (n) begin
      adc_a = 14'($random(seed));                          // fresh sample every cycle
      adc_b = 14'($random(seed));
      @(posedge adc_clk);
      #1;
    end
  endtask

  task automatic run_fixed(input logic [13:0] a, input logic [13:0] b, input int n);
    adc_a = a;
    adc_b = b;
    repeat (n) @(posedge adc_clk);
    #1;
  endtask

  // ------------------------------
  // compare dac ports, 4 cycles behind the adc input
  always @(negedge adc_clk) begin
    if (!check_en) begin
      fill = 0;
    end else begin
      if (fill >= 4) begin
        check_value("dac_dat_a_o", pipe_a[3], dac_a);
        check_value("dac_dat_b_o", pipe_b[3], dac_b);
      end
      for (int i = 3; i > 0; i--) begin
        pipe_a[i] = pipe_a[i-1];
        pipe_b[i] = pipe_b[i-1];
      end
      pipe_a[0] = dac_ref(adc_a, sp_m[0], kp_m[0], ofs_m[0]);
      pipe_b[0] = dac_ref(adc_b, sp_m[1], kp_m[1], ofs_m[1]);
      if (fill < 4)
        fill++;
    end
  end

  // ------------------------------
  // stimulus
  initial begin : stimulus
    logic [31:0] data;
    seed      = 75101;
    rst_n     = 1'b0;
    adc_a     = '0;
    adc_b     = '0;
    exp_val   = '0;
    sys_addr  = '0;
    sys_wdata = '0;
    sys_wen   = 1'b0;
    sys_ren   = 1'b0;
    check_en  = 1'b0;
    fill      = 0;
    for (int i = 0; i < 2; i++) begin
      sp_m[i]  = 0;
      kp_m[i]  = 0;
      ofs_m[i] = 0;
    end
    repeat (10) @(posedge adc_clk);
    #1;
    rst_n = 1'b1;
    check_value("sys_ack_o", 0, sys_ack);
    check_value("sys_err_o", 0, sys_err);
    check_value("led_o", 0, led);
    check_value("dac_dat_a_o", 14'h1fff, dac_a);           // code of zero
    check_value("dac_dat_b_o", 14'h1fff, dac_b);

    // config region, free region, stray address
    bus_read(make_addr(SYSCONF_REGION, SYSCONF_ID_OFS));
    check_value("sys_rdata_o", 32'hfff00001, rd_data);
    check_value("sys_err_o", 0, rd_err);
    bus_read(make_addr(SYSCONF_REGION, SYSCONF_REGIONS_OFS));
    check_value("sys_rdata_o", 8, rd_data);
    bus_read(make_addr(5, 20'h10));
    check_value("sys_rdata_o", 0, rd_data);
    check_value("sys_err_o", 0, rd_err);
    bus_read(make_addr(20, 20'h0));
    check_value("sys_err_o", 1, rd_err);

    // housekeeping
    data = $random(seed);
    bus_write(make_addr(REGION_HK, HK_LED_OFS), data);
    check_value("led_o", data[7:0], led);
    bus_read(make_addr(REGION_HK, HK_LED_OFS));
    check_value("sys_rdata_o", {24'h0, data[7:0]}, rd_data);
    repeat (3) begin
      exp_val = 8'($random(seed));
      bus_read(make_addr(REGION_HK, HK_EXP_OFS));
      check_value("sys_rdata_o", {24'h0, exp_val}, rd_data);
    end

    // gains at zero, dac follows the offsets only
    check_en = 1'b1;
    run_random(20);
    set_offsets($random(seed), $random(seed));
    check_en = 1'b1;
    run_random(40);
    check_value("dac_dat_a_o", dac_code(ofs_m[0]), dac_a);
    check_value("dac_dat_b_o", dac_code(ofs_m[1]), dac_b);

    // full range gains, then small ones that stay linear
    repeat (3) begin
      set_gains(0, $random(seed), $random(seed));
      set_gains(1, $random(seed), $random(seed));
      set_offsets($random(seed) % 4096, $random(seed) % 4096);
      check_en = 1'b1;
      run_random(100);
    end
    set_gains(0, $random(seed), $random(seed) % 512);
    set_gains(1, $random(seed), $random(seed) % 512);
    check_en = 1'b1;
    run_random(100);

    // both rails on both channels
    for (int pol = 0; pol < 2; pol++) begin
      set_offsets(pol ? -8000 : 8000, pol ? 8000 : -8000);
      set_gains(0, pol ? -8192 : 8191, 8191);
      set_gains(1, pol ? 8191 : -8192, 8191);
      check_en = 1'b1;
      run_fixed(pol ? 14'h0000 : 14'h3fff, pol ? 14'h3fff : 14'h0000, 10);
      check_value("dac_dat_a_o", dac_code(pol ? -8192 : 8191), dac_a);
      check_value("dac_dat_b_o", dac_code(pol ? 8191 : -8192), dac_b);
    end

    check_en = 1'b0;
    $display("Testbench passed");
    $finish;
  end

endmodule

`default_nettype wire

// File: sim.f
rtl/rp_pkg.sv
rtl/sys_bus_decoder.sv
rtl/hk_regs.sv
rtl/adc_frontend.sv
rtl/pid_p.sv
rtl/dac_mixer.sv
rtl/rp_top.sv
verif/tb_rp_top.sv

// File: run.sh
#!/bin/sh
# compile with Verilator and run; exit status is the testbench result
set -e
cd "$(dirname "$0")"
verilator --binary --timing -Wno-fatal --top-module tb_rp_top -f sim.f -o tb_rp_top
./obj_dir/tb_rp_top
